// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv32i_core
LOG       ?= sim.log
FILELIST  ?= rv32i_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: decode_stage.sv
module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fd_valid,
  input  rv32i_isa_pkg::word_t    fd_pc,
  input  rv32i_isa_pkg::word_t    fd_instr,
  input  logic                    redirect,
  input  logic                    wb_en,
  input  rv32i_isa_pkg::reg_idx_t wb_rd,
  input  rv32i_isa_pkg::word_t    wb_data,
  exec_if.decode                  ex
);
  import rv32i_isa_pkg::*;
  import rv32i_ctrl_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      rs1_rf;
  word_t      rs2_rf;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      imm;
  alu_op_t    alu_f;
  control_t   ctrl;

  // Instruction fields
  assign opcode = opcode_t'(fd_instr[OPCODE_W-1:0]);
  assign funct3 = fd_instr[FUNCT3_LSB +: 3];
  assign alt    = fd_instr[ALT_BIT];
  assign rd     = fd_instr[RD_LSB +: REG_IDX_W];
  assign rs1    = fd_instr[RS1_LSB +: REG_IDX_W];
  assign rs2    = fd_instr[RS2_LSB +: REG_IDX_W];

  regfile u_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rs1_rf),
    .rdata2 (rs2_rf),
    .we     (wb_en),
    .waddr  (wb_rd),
    .wdata  (wb_data)
  );

  // ALU function, SUB only exists in the register form
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_f = (alt && (opcode == OPC_OP)) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_f = ALU_SLL;
      F3_SLT:     alu_f = ALU_SLT;
      F3_SLTU:    alu_f = ALU_SLTU;
      F3_XOR:     alu_f = ALU_XOR;
      F3_SRL_SRA: alu_f = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_f = ALU_OR;
      F3_AND:     alu_f = ALU_AND;
      default:    alu_f = ALU_ADD;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.br_funct3 = funct3;
    case (opcode)
      OPC_OP: begin
        ctrl.alu_op    = alu_f;
        ctrl.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.op2_sel   = OP2_IMM;
        ctrl.alu_op    = alu_f;
        ctrl.reg_write = 1'b1;
      end
      OPC_LUI: begin
        ctrl.op1_sel   = OP1_ZERO;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.imm_type  = IMM_U;
        ctrl.wb_sel    = WB_IMM;
        ctrl.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.op1_sel   = OP1_PC;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.imm_type  = IMM_U;
        ctrl.reg_write = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.imm_type = IMM_B;
        ctrl.branch   = 1'b1;
      end
      OPC_JAL: begin
        ctrl.imm_type  = IMM_J;
        ctrl.wb_sel    = WB_PC4;
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OPC_JALR: begin
        // ALU forms rs1 + imm as the raw target
        ctrl.op2_sel   = OP2_IMM;
        ctrl.wb_sel    = WB_PC4;
        ctrl.jump      = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.op2_sel   = OP2_IMM;
        ctrl.wb_sel    = WB_MEM;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OPC_STORE: begin
        ctrl.op2_sel   = OP2_IMM;
        ctrl.imm_type  = IMM_S;
        ctrl.mem_write = 1'b1;
      end
      // Unknown opcode retires as a NOP
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    case (ctrl.imm_type)
      IMM_I:   imm = {{20{fd_instr[31]}}, fd_instr[31:20]};
      IMM_S:   imm = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
      IMM_B:   imm = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7],
                      fd_instr[30:25], fd_instr[11:8], 1'b0};
      IMM_U:   imm = {fd_instr[31:12], 12'b0};
      IMM_J:   imm = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12],
                      fd_instr[20], fd_instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // Result of the instruction now in execute, loads included
  assign rs1_val = (wb_en && (wb_rd == rs1) && (rs1 != '0)) ? wb_data : rs1_rf;
  assign rs2_val = (wb_en && (wb_rd == rs2) && (rs2 != '0)) ? wb_data : rs2_rf;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex.valid <= 1'b0;
      ex.ctrl  <= '0;
    end else if (redirect || !fd_valid) begin
      ex.valid <= 1'b0;
      ex.ctrl  <= '0;
    end else begin
      ex.valid <= 1'b1;
      ex.ctrl  <= ctrl;
    end
  end

  always_ff @(posedge clk) begin
    ex.pc      <= fd_pc;
    ex.rs1_val <= rs1_val;
    ex.rs2_val <= rs2_val;
    ex.imm     <= imm;
    ex.rd      <= rd;
  end

endmodule

// File: exec_if.sv
interface exec_if;
  import rv32i_isa_pkg::*;
  import rv32i_ctrl_pkg::*;

  // Low for a bubble
  logic     valid;
  word_t    pc;
  control_t ctrl;
  // Operands after forwarding
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm;
  reg_idx_t rd;

  modport decode (
    output valid, pc, ctrl, rs1_val, rs2_val, imm, rd
  );

  modport execute (
    input valid, pc, ctrl, rs1_val, rs2_val, imm, rd
  );

endinterface

// File: execute_unit.sv
module execute_unit (
  exec_if.execute                 ex,
  output rv32i_isa_pkg::word_t    data_addr,
  output rv32i_isa_pkg::word_t    data_wdata,
  output logic [3:0]              data_we,
  output logic                    data_re,
  input  rv32i_isa_pkg::word_t    data_rdata,
  output logic                    redirect,
  output rv32i_isa_pkg::word_t    redirect_pc,
  output logic                    wb_en,
  output rv32i_isa_pkg::reg_idx_t wb_rd,
  output rv32i_isa_pkg::word_t    wb_data,
  output logic                    retire_valid,
  output rv32i_isa_pkg::word_t    retire_pc,
  output rv32i_isa_pkg::reg_idx_t retire_rd,
  output rv32i_isa_pkg::word_t    retire_data
);
  import rv32i_isa_pkg::*;
  import rv32i_ctrl_pkg::*;

  word_t op1;
  word_t op2;
  word_t alu_result;
  word_t pc_plus4;
  logic  br_cond;

  always_comb begin
    case (ex.ctrl.op1_sel)
      OP1_PC:   op1 = ex.pc;
      OP1_ZERO: op1 = '0;
      default:  op1 = ex.rs1_val;
    endcase
  end

  assign op2 = (ex.ctrl.op2_sel == OP2_IMM) ? ex.imm : ex.rs2_val;

  always_comb begin
    case (ex.ctrl.alu_op)
      ALU_ADD:  alu_result = op1 + op2;
      ALU_SUB:  alu_result = op1 - op2;
      ALU_SLL:  alu_result = op1 << op2[4:0];
      ALU_SLT:  alu_result = ($signed(op1) < $signed(op2)) ? 32'd1 : 32'd0;
      ALU_SLTU: alu_result = (op1 < op2) ? 32'd1 : 32'd0;
      ALU_XOR:  alu_result = op1 ^ op2;
      ALU_SRL:  alu_result = op1 >> op2[4:0];
      ALU_SRA:  alu_result = $signed(op1) >>> op2[4:0];
      ALU_OR:   alu_result = op1 | op2;
      ALU_AND:  alu_result = op1 & op2;
      default:  alu_result = op1 + op2;
    endcase
  end

  // Branch compare works on the forwarded register values
  always_comb begin
    case (ex.ctrl.br_funct3)
      F3_BEQ:  br_cond = (ex.rs1_val == ex.rs2_val);
      F3_BNE:  br_cond = (ex.rs1_val != ex.rs2_val);
      F3_BLT:  br_cond = ($signed(ex.rs1_val) < $signed(ex.rs2_val));
      F3_BGE:  br_cond = ($signed(ex.rs1_val) >= $signed(ex.rs2_val));
      F3_BLTU: br_cond = (ex.rs1_val < ex.rs2_val);
      F3_BGEU: br_cond = (ex.rs1_val >= ex.rs2_val);
      default: br_cond = 1'b0;
    endcase
  end

  assign redirect = ex.valid && (ex.ctrl.jump || (ex.ctrl.branch && br_cond));

  // JALR target comes from the ALU with bit 0 cleared
  assign redirect_pc = ex.ctrl.is_jalr ? {alu_result[31:1], 1'b0} : ex.pc + ex.imm;

  // Full-word accesses only
  assign data_addr  = alu_result;
  assign data_wdata = ex.rs2_val;
  assign data_we    = {4{ex.valid && ex.ctrl.mem_write}};
  assign data_re    = ex.valid && ex.ctrl.mem_read;

  assign pc_plus4 = ex.pc + WORD_BYTES;

  always_comb begin
    case (ex.ctrl.wb_sel)
      WB_MEM:  wb_data = data_rdata;
      WB_PC4:  wb_data = pc_plus4;
      WB_IMM:  wb_data = ex.imm;
      default: wb_data = alu_result;
    endcase
  end

  assign wb_en = ex.valid && ex.ctrl.reg_write;
  assign wb_rd = ex.rd;

  assign retire_valid = ex.valid;
  assign retire_pc    = ex.pc;
  assign retire_rd    = ex.ctrl.reg_write ? ex.rd : '0;
  assign retire_data  = wb_data;

endmodule

// File: fetch_unit.sv
module fetch_unit #(
  parameter rv32i_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 redirect,
  input  rv32i_isa_pkg::word_t redirect_pc,
  output rv32i_isa_pkg::word_t instr_addr,
  input  rv32i_isa_pkg::word_t instr_rdata,
  output logic                 fd_valid,
  output rv32i_isa_pkg::word_t fd_pc,
  output rv32i_isa_pkg::word_t fd_instr
);
  import rv32i_isa_pkg::*;

  word_t pc;
  word_t pc_next;

  // Instruction memory answers in the same cycle
  assign instr_addr = pc;

  // Taken branch or jump in execute overrides the sequential address
  assign pc_next = redirect ? redirect_pc : pc + WORD_BYTES;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= RESET_PC;
      fd_valid <= 1'b0;
    end else begin
      pc       <= pc_next;
      // Word fetched under a redirect is on the wrong path
      fd_valid <= ~redirect;
    end
  end

  always_ff @(posedge clk) begin
    fd_pc    <= pc;
    fd_instr <= instr_rdata;
  end

endmodule

// File: regfile.sv
module regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  rv32i_isa_pkg::reg_idx_t raddr1,
  input  rv32i_isa_pkg::reg_idx_t raddr2,
  output rv32i_isa_pkg::word_t    rdata1,
  output rv32i_isa_pkg::word_t    rdata2,
  input  logic                    we,
  input  rv32i_isa_pkg::reg_idx_t waddr,
  input  rv32i_isa_pkg::word_t    wdata
);
  import rv32i_isa_pkg::*;

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // No internal bypass, decode forwards the write-back value itself
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rv32i_checker.sv
module rv32i_checker #(
  parameter rv32i_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  rv32i_isa_pkg::word_t    instr_addr,
  input  rv32i_isa_pkg::word_t    data_addr,
  input  rv32i_isa_pkg::word_t    data_wdata,
  input  logic [3:0]              data_we,
  input  logic                    data_re,
  input  logic                    retire_valid,
  input  rv32i_isa_pkg::word_t    retire_pc,
  input  rv32i_isa_pkg::reg_idx_t retire_rd,
  input  rv32i_isa_pkg::word_t    retire_data,
  input  rv32i_isa_pkg::word_t    prog [256],
  input  rv32i_isa_pkg::word_t    data_image [64],
  input  logic                    end_of_run,
  input  logic                    completed,
  output logic                    report_done,
  output int                      fail_count
);
  timeunit 1ns;
  timeprecision 1ns;
  import rv32i_isa_pkg::*;

  // Architectural state of the model
  word_t    regs [32];
  word_t    mem [64];
  word_t    pc;
  reg_idx_t last_rd;

  int   checks [1:6] = '{default: 0};
  int   fails [1:6] = '{default: 0};
  int   reset_edges = 0;
  logic after_reset;
  logic first_retired;

  function automatic string test_label(input int t);
    case (t)
      1:       return "reset";
      2:       return "alu results";
      3:       return "dependencies";
      4:       return "control flow";
      5:       return "memory";
      default: return "completion";
    endcase
  endfunction

  task automatic print_test_line(input int t);
    $display("Test %0d %s: %s, %0d checks, %0d errors", t, test_label(t),
             (fails[t] == 0) ? "PASS" : "FAIL", checks[t], fails[t]);
  endtask

  task automatic compare_value(input int test, input string name, input word_t got,
                               input word_t expected);
    checks[test]++;
    if (got !== expected) begin
      fails[test]++;
      $display("ERROR %s: got %h, expected %h (model pc %h)", name, got, expected, pc);
    end
  endtask

  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    word_t r;
    case (f3)
      F3_ADD_SUB: r = alt ? a - b : a + b;
      F3_SLL:     r = a << b[4:0];
      F3_SLT:     r = {31'd0, $signed(a) < $signed(b)};
      F3_SLTU:    r = {31'd0, a < b};
      F3_XOR:     r = a ^ b;
      F3_SRL_SRA: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      F3_OR:      r = a | b;
      default:    r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a,
                                        input word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Quiet outputs expected around reset
  task automatic check_idle_outputs();
    compare_value(1, "retire_valid", {31'd0, retire_valid}, 32'd0);
    compare_value(1, "data_we", {28'd0, data_we}, 32'd0);
    compare_value(1, "data_re", {31'd0, data_re}, 32'd0);
    compare_value(1, "instr_addr", instr_addr, RESET_PC);
  endtask

  // Executes the instruction at the model pc and checks the retire
  task automatic step_model();
    word_t      offset;
    word_t      instr;
    word_t      a;
    word_t      b;
    word_t      result;
    word_t      next_pc;
    word_t      addr;
    logic [6:0] opc;
    logic [2:0] f3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       writes;
    logic       uses_rs1;
    logic       uses_rs2;
    int         cat;
    offset   = (pc - RESET_PC) >> 2;
    instr    = prog[offset[7:0]];
    opc      = instr[6:0];
    rd       = instr[11:7];
    f3       = instr[14:12];
    rs1      = instr[19:15];
    rs2      = instr[24:20];
    a        = regs[rs1];
    b        = regs[rs2];
    result   = '0;
    addr     = '0;
    writes   = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    next_pc  = pc + 32'd4;
    case (opc)
      OPC_OP: begin
        result   = alu_model(f3, instr[30], a, b);
        writes   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OPC_OP_IMM: begin
        // Only SRAI takes bit 30 as a function bit
        result   = alu_model(f3, (f3 == F3_SRL_SRA) && instr[30], a,
                             {{20{instr[31]}}, instr[31:20]});
        writes   = 1'b1;
        uses_rs1 = 1'b1;
      end
      OPC_LUI: begin
        result = {instr[31:12], 12'd0};
        writes = 1'b1;
      end
      OPC_AUIPC: begin
        result = pc + {instr[31:12], 12'd0};
        writes = 1'b1;
      end
      OPC_JAL: begin
        result  = pc + 32'd4;
        writes  = 1'b1;
        next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      OPC_JALR: begin
        result   = pc + 32'd4;
        writes   = 1'b1;
        uses_rs1 = 1'b1;
        next_pc  = (a + {{20{instr[31]}}, instr[31:20]}) & ~32'd1;
      end
      OPC_BRANCH: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        if (branch_taken(f3, a, b)) begin
          next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
      end
      OPC_LOAD: begin
        addr     = a + {{20{instr[31]}}, instr[31:20]};
        result   = mem[addr[7:2]];
        writes   = 1'b1;
        uses_rs1 = 1'b1;
      end
      OPC_STORE: begin
        addr     = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: ;
    endcase

    compare_value(4, "retire_pc", retire_pc, pc);

    // Loads count as memory, consumers of the previous result as dependencies
    if (opc == OPC_LOAD) begin
      cat = 5;
    end else if (last_rd != '0 && ((uses_rs1 && rs1 == last_rd) ||
                                   (uses_rs2 && rs2 == last_rd))) begin
      cat = 3;
    end else begin
      cat = 2;
    end
    compare_value(cat, "retire_rd", {27'd0, retire_rd}, {27'd0, writes ? rd : 5'd0});
    if (writes && rd != '0) begin
      compare_value(cat, "retire_data", retire_data, result);
    end

    compare_value(5, "data_we", {28'd0, data_we}, (opc == OPC_STORE) ? 32'hf : 32'h0);
    compare_value(5, "data_re", {31'd0, data_re}, (opc == OPC_LOAD) ? 32'd1 : 32'd0);
    if (opc == OPC_STORE) begin
      compare_value(5, "data_addr", data_addr, addr);
      compare_value(5, "data_wdata", data_wdata, b);
      mem[addr[7:2]] = b;
    end else if (opc == OPC_LOAD) begin
      compare_value(5, "data_addr", data_addr, addr);
    end

    if (writes && rd != '0) begin
      regs[rd] = result;
    end
    last_rd = writes ? rd : '0;
    pc      = next_pc;
  endtask

  task automatic report_results();
    int passed;
    int failed;
    int errors;
    passed = 0;
    failed = 0;
    errors = 0;
    if (!first_retired) begin
      checks[1]++;
      fails[1]++;
      $display("No instruction retired after reset");
      print_test_line(1);
    end
    checks[6]++;
    if (!completed) begin
      fails[6]++;
    end
    for (int t = 2; t <= 6; t++) begin
      print_test_line(t);
    end
    for (int t = 1; t <= 6; t++) begin
      errors += fails[t];
      if (fails[t] == 0) begin
        passed++;
      end else begin
        failed++;
      end
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
    fail_count  = errors;
    report_done = 1'b1;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
        mem[i] = data_image[i];
      end
      pc            = RESET_PC;
      last_rd       = '0;
      after_reset   = 1'b1;
      first_retired = 1'b0;
      report_done   = 1'b0;
      fail_count    = 0;
      // Flops settle on the first reset edge
      if (reset_edges > 0) begin
        check_idle_outputs();
      end
      reset_edges++;
    end else begin
      if (after_reset) begin
        check_idle_outputs();
        after_reset = 1'b0;
      end
      if (retire_valid) begin
        if (!first_retired) begin
          compare_value(1, "retire_pc", retire_pc, RESET_PC);
          print_test_line(1);
          first_retired = 1'b1;
        end
        step_model();
      end else begin
        compare_value(5, "data_we", {28'd0, data_we}, 32'd0);
      end
      if (end_of_run && !report_done) begin
        report_results();
      end
    end
  end

endmodule

// File: rv32i_core.f
rv32i_isa_pkg.sv
rv32i_ctrl_pkg.sv
exec_if.sv
regfile.sv
fetch_unit.sv
decode_stage.sv
execute_unit.sv
rv32i_core.sv
rv32i_checker.sv
tb_rv32i_core.sv

// File: rv32i_core.sv
module rv32i_core #(
  parameter rv32i_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  output rv32i_isa_pkg::word_t    instr_addr,
  input  rv32i_isa_pkg::word_t    instr_rdata,
  output rv32i_isa_pkg::word_t    data_addr,
  output rv32i_isa_pkg::word_t    data_wdata,
  output logic [3:0]              data_we,
  output logic                    data_re,
  input  rv32i_isa_pkg::word_t    data_rdata,
  output logic                    retire_valid,
  output rv32i_isa_pkg::word_t    retire_pc,
  output rv32i_isa_pkg::reg_idx_t retire_rd,
  output rv32i_isa_pkg::word_t    retire_data
);
  import rv32i_isa_pkg::*;

  logic     redirect;
  word_t    redirect_pc;
  logic     fd_valid;
  word_t    fd_pc;
  word_t    fd_instr;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // Decode/execute pipeline register contents
  exec_if ex_bus ();

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .fd_valid    (fd_valid),
    .fd_pc       (fd_pc),
    .fd_instr    (fd_instr)
  );

  decode_stage u_decode (
    .clk      (clk),
    .rst      (rst),
    .fd_valid (fd_valid),
    .fd_pc    (fd_pc),
    .fd_instr (fd_instr),
    .redirect (redirect),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .ex       (ex_bus.decode)
  );

  execute_unit u_execute (
    .ex           (ex_bus.execute),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_we      (data_we),
    .data_re      (data_re),
    .data_rdata   (data_rdata),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

// File: rv32i_ctrl_pkg.sv
package rv32i_ctrl_pkg;

  // First ALU operand
  typedef enum logic [1:0] {
    OP1_RS1  = 2'd0,
    OP1_PC   = 2'd1,
    OP1_ZERO = 2'd2
  } op1_sel_t;

  // Second ALU operand
  typedef enum logic {
    OP2_RS2 = 1'b0,
    OP2_IMM = 1'b1
  } op2_sel_t;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2,
    WB_IMM = 2'd3
  } wb_sel_t;

  // Immediate formats
  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_type_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // All-zero value is a harmless bubble
  typedef struct packed {
    op1_sel_t   op1_sel;
    op2_sel_t   op2_sel;
    wb_sel_t    wb_sel;
    imm_type_t  imm_type;
    alu_op_t    alu_op;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jump;
    logic       is_jalr;
    logic [2:0] br_funct3;
  } control_t;

endpackage

// File: rv32i_isa_pkg.sv
package rv32i_isa_pkg;

  // Machine word
  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] word_t;

  // Sequential PC step
  localparam word_t WORD_BYTES = 32'd4;

  // Register index
  localparam int REG_IDX_W = 5;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Instruction field positions
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  // funct7 bit that selects SUB and SRA
  localparam int ALT_BIT    = 30;

  // Opcodes of the supported subset
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU functions, register and immediate forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: tb_rv32i_core.sv
module tb_rv32i_core;
  timeunit 1ns;
  timeprecision 1ns;
  import rv32i_isa_pkg::*;

  localparam word_t RESET_PC     = 32'h0000_0100;
  localparam int    PROG_LEN     = 200;
  localparam word_t FINAL_PC     = RESET_PC + word_t'(4 * (PROG_LEN - 1));
  localparam int    RUN_LIMIT    = 2000;
  localparam int    REPORT_LIMIT = 10;

  logic     clk;
  logic     rst;
  word_t    instr_addr;
  word_t    instr_rdata;
  word_t    data_addr;
  word_t    data_wdata;
  logic [3:0] data_we;
  logic     data_re;
  word_t    data_rdata;
  logic     retire_valid;
  word_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_data;
  logic     end_of_run;
  logic     completed;
  logic     report_done;
  int       fail_count;

  // Instruction memory, data memory and its image at reset
  word_t imem [256];
  word_t dmem [64];
  word_t dmem_init [64];
  word_t imem_offset;

  rv32i_core #(
    .RESET_PC (RESET_PC)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .instr_addr   (instr_addr),
    .instr_rdata  (instr_rdata),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_we      (data_we),
    .data_re      (data_re),
    .data_rdata   (data_rdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  rv32i_checker #(
    .RESET_PC (RESET_PC)
  ) chk_i (
    .clk          (clk),
    .rst          (rst),
    .instr_addr   (instr_addr),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_we      (data_we),
    .data_re      (data_re),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .prog         (imem),
    .data_image   (dmem_init),
    .end_of_run   (end_of_run),
    .completed    (completed),
    .report_done  (report_done),
    .fail_count   (fail_count)
  );

  // Both memories answer in the same cycle
  assign imem_offset = (instr_addr - RESET_PC) >> 2;
  assign instr_rdata = imem[imem_offset[7:0]];
  assign data_rdata  = dmem[data_addr[7:2]];

  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= dmem_init[i];
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (data_we[b]) begin
          dmem[data_addr[7:2]][8*b +: 8] <= data_wdata[8*b +: 8];
        end
      end
    end
  end

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd, input opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [19:0] upper, input reg_idx_t rd,
                                   input opcode_t opc);
    return {upper, rd, opc};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Random program over x0..x7, all control flow jumps forward
  task automatic build_program();
    word_t      instr;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] f3;
    logic [11:0] imm;
    int         span;
    int         kind;
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP_INSTR;
    end
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      rd   = reg_idx_t'($urandom % 8);
      rs1  = reg_idx_t'($urandom % 8);
      rs2  = reg_idx_t'($urandom % 8);
      span = PROG_LEN - 1 - i;
      if (span > 8) begin
        span = 8;
      end
      kind = $urandom % 16;
      case (kind)
        0, 1, 2, 3, 4: begin
          f3 = 3'($urandom);
          imm[0] = (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) ? 1'($urandom) : 1'b0;
          instr = r_type({1'b0, imm[0], 5'd0}, rs2, rs1, f3, rd, OPC_OP);
        end
        5, 6, 7, 8: begin
          f3  = 3'($urandom);
          imm = 12'($urandom);
          // Shift immediates carry a 5-bit amount
          if (f3 == F3_SLL) begin
            imm = {7'd0, imm[4:0]};
          end else if (f3 == F3_SRL_SRA) begin
            imm = {1'b0, imm[11], 5'd0, imm[4:0]};
          end
          instr = i_type(imm, rs1, f3, rd, OPC_OP_IMM);
        end
        9:  instr = u_type(20'($urandom), rd, OPC_LUI);
        10: instr = u_type(20'($urandom), rd, OPC_AUIPC);
        11, 12: begin
          // Maps 0..5 onto the six branch encodings
          f3 = 3'($urandom % 6);
          if (f3 >= 3'd2) begin
            f3 = f3 + 3'd2;
          end
          instr = b_type(13'(4 * (1 + $urandom % span)), rs2, rs1, f3);
        end
        13: begin
          if ($urandom % 2 == 0) begin
            instr = j_type(21'(4 * (1 + $urandom % span)), rd);
          end else begin
            imm   = 12'(RESET_PC + 4 * (i + 1 + $urandom % span));
            instr = i_type(imm, 5'd0, 3'b000, rd, OPC_JALR);
          end
        end
        14: instr = i_type(12'(4 * ($urandom % 64)), 5'd0, 3'b010, rd, OPC_LOAD);
        default: instr = s_type(12'(4 * ($urandom % 64)), rs2, 5'd0);
      endcase
      imem[i] = instr;
    end
    // Final self-jump
    imem[PROG_LEN-1] = j_type(21'd0, 5'd0);
    for (int i = 0; i < 64; i++) begin
      dmem_init[i] = $urandom;
    end
  endtask

  task automatic wait_for_final(output logic found);
    int cycles;
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < RUN_LIMIT) begin
      @(posedge clk);
      if (retire_valid && retire_pc == FINAL_PC) begin
        found = 1'b1;
      end
      cycles++;
    end
  endtask

  task automatic wait_for_report(output logic reported);
    int cycles;
    reported = 1'b0;
    cycles   = 0;
    while (!reported && cycles < REPORT_LIMIT) begin
      @(negedge clk);
      reported = report_done;
      cycles++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    logic found;
    logic reported;
    void'($urandom(32'h39c79a2b));
    rst        = 1'b1;
    end_of_run = 1'b0;
    completed  = 1'b0;
    build_program();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    wait_for_final(found);
    if (!found) begin
      $display("Timeout: the final self-jump at %h did not retire within %0d cycles",
               FINAL_PC, RUN_LIMIT);
    end
    @(negedge clk);
    completed  = found;
    end_of_run = 1'b1;
    wait_for_report(reported);
    if (!reported) begin
      $display("The checker gave no report within %0d cycles", REPORT_LIMIT);
    end
    if (found && reported && fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
